//--- hw/bp_pkg.sv
// shared widths, fetch geometry and per-entry record types of the branch predictor
package bp_pkg;

  // --------------------------------------------------
  // address and fetch geometry
  // --------------------------------------------------
  localparam int unsigned VLEN = 32;
  localparam int unsigned INSTR_PER_FETCH = 2;
  // compressed instructions, so only bit 0 is always zero
  localparam int unsigned PC_OFFSET = 1;
  localparam int unsigned SLOT_BITS = $clog2(INSTR_PER_FETCH);

  // widest BTB tag, reached with the smallest legal table of two rows
  localparam int unsigned BTB_TAG_BITS = VLEN - PC_OFFSET - SLOT_BITS - 1;

  // --------------------------------------------------
  // table cells
  // --------------------------------------------------
  typedef struct packed {
    logic       valid;
    logic [1:0] counter;
  } bht_entry_t;

  // tag is kept zero extended, the btb fills in as many bits as its index leaves
  typedef struct packed {
    logic                    valid;
    logic [BTB_TAG_BITS-1:0] tag;
    logic [VLEN-1:0]         target;
  } btb_entry_t;

  // --------------------------------------------------
  // per-slot prediction
  // --------------------------------------------------
  typedef struct packed {
    logic            valid;
    logic            taken;
    logic            target_valid;
    logic [VLEN-1:0] target;
  } bp_prediction_t;

endpackage

//--- hw/bp_update_if.sv
// training write interface from the update arbiter to the BHT and BTB
`timescale 1ns/1ps

interface bp_update_if;
  import bp_pkg::*;

  // one resolved branch, written into both tables on the edge where valid is high
  logic            valid;
  logic [VLEN-1:0] pc;
  logic            taken;
  logic [VLEN-1:0] target;

  // arbiter side
  modport source (
    output valid,
    output pc,
    output taken,
    output target
  );

  // table side
  modport sink (
    input valid,
    input pc,
    input taken,
    input target
  );

endinterface

//--- hw/bp_update_arbiter.sv
// round-robin merge of two resolve ports onto the shared table update path
`timescale 1ns/1ps

module bp_update_arbiter (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     flush_i,
  input  logic                     debug_mode_i,
  // resolve port 0
  input  logic                     res0_valid_i,
  input  logic [bp_pkg::VLEN-1:0]  res0_pc_i,
  input  logic                     res0_taken_i,
  input  logic [bp_pkg::VLEN-1:0]  res0_target_i,
  output logic                     res0_ready_o,
  // resolve port 1
  input  logic                     res1_valid_i,
  input  logic [bp_pkg::VLEN-1:0]  res1_pc_i,
  input  logic                     res1_taken_i,
  input  logic [bp_pkg::VLEN-1:0]  res1_target_i,
  output logic                     res1_ready_o,
  // towards both tables
  bp_update_if.source              upd
);

  logic hold;
  logic gnt0;
  logic gnt1;
  // 0 favours port 0 on a conflict, 1 favours port 1
  logic rr_q;
  logic rr_d;

  // --------------------------------------------------
  // grant
  // --------------------------------------------------
  // tables are busy with a clear or flush, nothing may be consumed
  assign hold = clear_i | flush_i;

  assign gnt0 = ~hold & res0_valid_i & (~res1_valid_i | ~rr_q);
  assign gnt1 = ~hold & res1_valid_i & (~res0_valid_i | rr_q);

  assign res0_ready_o = gnt0;
  assign res1_ready_o = gnt1;

  // after a grant the other port gets the next conflict
  always_comb begin
    rr_d = rr_q;
    if (gnt0) begin
      rr_d = 1'b1;
    end else if (gnt1) begin
      rr_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= 1'b0;
    end else begin
      rr_q <= rr_d;
    end
  end

  // --------------------------------------------------
  // update path
  // --------------------------------------------------
  // in debug mode the branch is consumed but does not train
  assign upd.valid  = (gnt0 | gnt1) & ~debug_mode_i;
  assign upd.pc     = gnt1 ? res1_pc_i : res0_pc_i;
  assign upd.taken  = gnt1 ? res1_taken_i : res0_taken_i;
  assign upd.target = gnt1 ? res1_target_i : res0_target_i;

endmodule

//--- hw/bht.sv
// branch history table of 2-bit saturating counters, one row per fetch block
`timescale 1ns/1ps

module bht #(
  parameter int unsigned NrBhtEntries = 64
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   flush_i,
  input  logic [bp_pkg::VLEN-1:0] vpc_i,
  bp_update_if.sink              upd,
  output bp_pkg::bp_prediction_t [bp_pkg::INSTR_PER_FETCH-1:0] bht_pred_o
);
  import bp_pkg::*;

  localparam int unsigned NrRows = NrBhtEntries / INSTR_PER_FETCH;
  localparam int unsigned IdxBits = $clog2(NrRows);
  // lowest PC bit of the row index
  localparam int unsigned IdxLsb = PC_OFFSET + SLOT_BITS;

  bht_entry_t bht_q [NrRows-1:0][INSTR_PER_FETCH-1:0];

  logic [IdxBits-1:0]   fetch_idx;
  logic [IdxBits-1:0]   upd_idx;
  logic [SLOT_BITS-1:0] upd_slot;
  bht_entry_t           upd_cur;
  bht_entry_t           upd_new;

  // --------------------------------------------------
  // index decode
  // --------------------------------------------------
  assign fetch_idx = vpc_i[IdxLsb +: IdxBits];
  assign upd_idx   = upd.pc[IdxLsb +: IdxBits];
  // slot inside the fetch block
  assign upd_slot  = upd.pc[PC_OFFSET +: SLOT_BITS];

  // --------------------------------------------------
  // prediction
  // --------------------------------------------------
  // whole row is read, the fetch stage picks its slots
  always_comb begin
    for (int i = 0; i < INSTR_PER_FETCH; i++) begin
      bht_pred_o[i]       = '0;
      bht_pred_o[i].valid = bht_q[fetch_idx][i].valid;
      bht_pred_o[i].taken = bht_q[fetch_idx][i].counter[1];
    end
  end

  // --------------------------------------------------
  // training
  // --------------------------------------------------
  assign upd_cur = bht_q[upd_idx][upd_slot];

  // saturating step, stays at 11 when taken and at 00 when not taken
  always_comb begin
    upd_new       = upd_cur;
    upd_new.valid = 1'b1;
    if (upd.taken) begin
      if (upd_cur.counter != 2'b11) begin
        upd_new.counter = upd_cur.counter + 2'd1;
      end
    end else begin
      if (upd_cur.counter != 2'b00) begin
        upd_new.counter = upd_cur.counter - 2'd1;
      end
    end
  end

  // clear beats flush, both beat a training write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < NrRows; r++) begin
        for (int s = 0; s < INSTR_PER_FETCH; s++) begin
          bht_q[r][s] <= '0;
        end
      end
    end else if (clear_i) begin
      for (int r = 0; r < NrRows; r++) begin
        for (int s = 0; s < INSTR_PER_FETCH; s++) begin
          bht_q[r][s] <= '0;
        end
      end
    end else if (flush_i) begin
      // invalidate, counters restart weakly taken
      for (int r = 0; r < NrRows; r++) begin
        for (int s = 0; s < INSTR_PER_FETCH; s++) begin
          bht_q[r][s].valid   <= 1'b0;
          bht_q[r][s].counter <= 2'b10;
        end
      end
    end else if (upd.valid) begin
      bht_q[upd_idx][upd_slot] <= upd_new;
    end
  end

endmodule

//--- hw/btb.sv
// direct-mapped branch target buffer with tag compare, one row per fetch block
`timescale 1ns/1ps

module btb #(
  parameter int unsigned NrBtbEntries = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   flush_i,
  input  logic [bp_pkg::VLEN-1:0] vpc_i,
  bp_update_if.sink              upd,
  output bp_pkg::bp_prediction_t [bp_pkg::INSTR_PER_FETCH-1:0] btb_pred_o
);
  import bp_pkg::*;

  localparam int unsigned NrRows = NrBtbEntries / INSTR_PER_FETCH;
  localparam int unsigned IdxBits = $clog2(NrRows);
  localparam int unsigned IdxLsb = PC_OFFSET + SLOT_BITS;
  // everything above the index is tag
  localparam int unsigned TagLsb = IdxLsb + IdxBits;

  btb_entry_t btb_q [NrRows-1:0][INSTR_PER_FETCH-1:0];

  logic [IdxBits-1:0]      fetch_idx;
  logic [BTB_TAG_BITS-1:0] fetch_tag;
  logic [IdxBits-1:0]      upd_idx;
  logic [SLOT_BITS-1:0]    upd_slot;
  logic [BTB_TAG_BITS-1:0] upd_tag;

  // upper PC bits, zero extended into the tag field
  function automatic logic [BTB_TAG_BITS-1:0] tag_of(input logic [VLEN-1:0] pc);
    logic [VLEN-1:0] shifted;
    shifted = pc >> TagLsb;
    return shifted[BTB_TAG_BITS-1:0];
  endfunction

  // --------------------------------------------------
  // index and tag decode
  // --------------------------------------------------
  assign fetch_idx = vpc_i[IdxLsb +: IdxBits];
  assign fetch_tag = tag_of(vpc_i);
  assign upd_idx   = upd.pc[IdxLsb +: IdxBits];
  assign upd_slot  = upd.pc[PC_OFFSET +: SLOT_BITS];
  assign upd_tag   = tag_of(upd.pc);

  // --------------------------------------------------
  // prediction
  // --------------------------------------------------
  // a hit needs a valid entry from the same tag
  always_comb begin
    for (int i = 0; i < INSTR_PER_FETCH; i++) begin
      btb_pred_o[i]              = '0;
      btb_pred_o[i].target_valid = btb_q[fetch_idx][i].valid &&
                                   (btb_q[fetch_idx][i].tag == fetch_tag);
      btb_pred_o[i].target       = btb_q[fetch_idx][i].target;
    end
  end

  // --------------------------------------------------
  // training
  // --------------------------------------------------
  // only taken branches allocate, not-taken ones leave the entry alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < NrRows; r++) begin
        for (int s = 0; s < INSTR_PER_FETCH; s++) begin
          btb_q[r][s] <= '0;
        end
      end
    end else if (clear_i) begin
      for (int r = 0; r < NrRows; r++) begin
        for (int s = 0; s < INSTR_PER_FETCH; s++) begin
          btb_q[r][s] <= '0;
        end
      end
    end else if (flush_i) begin
      for (int r = 0; r < NrRows; r++) begin
        for (int s = 0; s < INSTR_PER_FETCH; s++) begin
          btb_q[r][s].valid <= 1'b0;
        end
      end
    end else if (upd.valid && upd.taken) begin
      btb_q[upd_idx][upd_slot].valid  <= 1'b1;
      btb_q[upd_idx][upd_slot].tag    <= upd_tag;
      btb_q[upd_idx][upd_slot].target <= upd.target;
    end
  end

endmodule

//--- hw/branch_predictor.sv
// fetch-stage branch predictor top: update arbiter, BHT and BTB
`timescale 1ns/1ps

module branch_predictor #(
  parameter int unsigned NrBhtEntries = 64,
  parameter int unsigned NrBtbEntries = 16
) (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic                                                clear_i,
  input  logic                                                flush_i,
  input  logic                                                debug_mode_i,
  input  logic [bp_pkg::VLEN-1:0]                             vpc_i,
  // resolve port 0
  input  logic                                                res0_valid_i,
  input  logic [bp_pkg::VLEN-1:0]                             res0_pc_i,
  input  logic                                                res0_taken_i,
  input  logic [bp_pkg::VLEN-1:0]                             res0_target_i,
  output logic                                                res0_ready_o,
  // resolve port 1
  input  logic                                                res1_valid_i,
  input  logic [bp_pkg::VLEN-1:0]                             res1_pc_i,
  input  logic                                                res1_taken_i,
  input  logic [bp_pkg::VLEN-1:0]                             res1_target_i,
  output logic                                                res1_ready_o,
  // per-slot prediction
  output logic [bp_pkg::INSTR_PER_FETCH-1:0]                  pred_valid_o,
  output logic [bp_pkg::INSTR_PER_FETCH-1:0]                  pred_taken_o,
  output logic [bp_pkg::INSTR_PER_FETCH-1:0]                  pred_target_valid_o,
  output logic [bp_pkg::INSTR_PER_FETCH-1:0][bp_pkg::VLEN-1:0] pred_target_o
);
  import bp_pkg::*;

  bp_prediction_t [INSTR_PER_FETCH-1:0] bht_pred;
  bp_prediction_t [INSTR_PER_FETCH-1:0] btb_pred;

  // shared training write
  bp_update_if upd_if ();

  bp_update_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .flush_i       (flush_i),
    .debug_mode_i  (debug_mode_i),
    .res0_valid_i  (res0_valid_i),
    .res0_pc_i     (res0_pc_i),
    .res0_taken_i  (res0_taken_i),
    .res0_target_i (res0_target_i),
    .res0_ready_o  (res0_ready_o),
    .res1_valid_i  (res1_valid_i),
    .res1_pc_i     (res1_pc_i),
    .res1_taken_i  (res1_taken_i),
    .res1_target_i (res1_target_i),
    .res1_ready_o  (res1_ready_o),
    .upd           (upd_if)
  );

  bht #(
    .NrBhtEntries (NrBhtEntries)
  ) u_bht (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .flush_i    (flush_i),
    .vpc_i      (vpc_i),
    .upd        (upd_if),
    .bht_pred_o (bht_pred)
  );

  btb #(
    .NrBtbEntries (NrBtbEntries)
  ) u_btb (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .flush_i    (flush_i),
    .vpc_i      (vpc_i),
    .upd        (upd_if),
    .btb_pred_o (btb_pred)
  );

  // direction from the bht, target from the btb
  for (genvar i = 0; i < INSTR_PER_FETCH; i++) begin : gen_slot_out
    assign pred_valid_o[i]        = bht_pred[i].valid;
    assign pred_taken_o[i]        = bht_pred[i].taken;
    assign pred_target_valid_o[i] = btb_pred[i].target_valid;
    assign pred_target_o[i]       = btb_pred[i].target;
  end

endmodule

//--- bench/tb_branch_predictor.sv
// clock, reset, LFSR stimulus, shadow tables and output checks for the branch predictor testbench
`timescale 1ns/1ps

module tb_branch_predictor;

  localparam int BHT_ENTRIES = 64;
  localparam int BTB_ENTRIES = 16;
  localparam int BHT_HI = $clog2(BHT_ENTRIES);
  localparam int BTB_HI = $clog2(BTB_ENTRIES);
  localparam int WAIT_LIMIT = 50;
  localparam int STREAM_LEN = 24;
  localparam logic [31:0] PC_A = 32'h0000_1006;
  // same BTB index and slot as PC_A with another tag
  localparam logic [31:0] PC_A_ALIAS = 32'h0000_3006;
  localparam logic [31:0] PC_B = 32'h0000_2018;
  localparam logic [31:0] TGT_A = 32'h0000_4a20;
  localparam logic [31:0] TGT_B = 32'h0000_7f14;

  logic clk_i, rst_ni, clear_i, flush_i, debug_mode_i;
  logic [31:0] vpc_i;
  logic res0_valid_i, res0_taken_i, res0_ready_o;
  logic [31:0] res0_pc_i, res0_target_i;
  logic res1_valid_i, res1_taken_i, res1_ready_o;
  logic [31:0] res1_pc_i, res1_target_i;
  logic [1:0] pred_valid_o, pred_taken_o, pred_target_valid_o;
  logic [1:0][31:0] pred_target_o;

  int errors = 0;
  int timeouts = 0;
  int sent = 0;
  int accepted = 0;
  logic [31:0] lfsr_state = 32'he5a5_924f;

  // shadow tables and arbiter pointer
  logic m_bht_v [BHT_ENTRIES];
  logic [1:0] m_bht_c [BHT_ENTRIES];
  logic m_btb_v [BTB_ENTRIES];
  logic [31:0] m_btb_tag [BTB_ENTRIES];
  logic [31:0] m_btb_tgt [BTB_ENTRIES];
  logic favour1;
  logic [1:0] exp_valid, exp_taken, exp_tvalid;
  logic [31:0] exp_target [2];
  logic exp_rdy0, exp_rdy1;

  // pre-generated resolve streams for the two ports
  logic [31:0] s_pc [2][STREAM_LEN];
  logic [31:0] s_tgt [2][STREAM_LEN];
  logic s_tk [2][STREAM_LEN];
  logic s_idle [2][STREAM_LEN];

  branch_predictor u_dut (.*);

  always #4 clk_i = ~clk_i;

  // --------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------
  // taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_bit()};
    end
    return r;
  endfunction

  // bit 5 is the lowest BTB tag bit, so k and k^16 collide in the BTB
  function automatic logic [31:0] pool_pc(input logic [4:0] k);
    return 32'h0000_8000 | {26'b0, k, 1'b0};
  endfunction

  task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    errors++;
    $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
  endtask

  task automatic send_resolve(input int port, input logic [31:0] pc, input logic taken,
                              input logic [31:0] target);
    int waited;
    logic got;
    waited = 0;
    got = 1'b0;
    if (port == 0) begin
      {res0_valid_i, res0_pc_i, res0_taken_i, res0_target_i} = {1'b1, pc, taken, target};
    end else begin
      {res1_valid_i, res1_pc_i, res1_taken_i, res1_target_i} = {1'b1, pc, taken, target};
    end
    while (!got && waited < WAIT_LIMIT) begin
      @(negedge clk_i);
      got = (port == 0) ? res0_ready_o : res1_ready_o;
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (port == 0) res0_valid_i = 1'b0;
    else res1_valid_i = 1'b0;
    sent++;
    if (!got) begin
      timeouts++;
      $display("timeout: resolve port %0d never saw ready", port);
    end
  endtask

  task automatic expect_slot(input logic [31:0] pc, input logic valid, input logic taken,
                             input logic tvalid, input logic [31:0] target);
    int s;
    s = int'(pc[1]);
    vpc_i = pc;
    @(negedge clk_i);
    chk_valid: assert (pred_valid_o[s] == valid)
      else report_value("pred_valid_o", {31'b0, pred_valid_o[s]}, {31'b0, valid});
    chk_taken: assert (pred_taken_o[s] == taken)
      else report_value("pred_taken_o", {31'b0, pred_taken_o[s]}, {31'b0, taken});
    chk_tvalid: assert (pred_target_valid_o[s] == tvalid)
      else report_value("pred_target_valid_o", {31'b0, pred_target_valid_o[s]}, {31'b0, tvalid});
    chk_target: assert (!tvalid || pred_target_o[s] == target)
      else report_value("pred_target_o", pred_target_o[s], target);
    @(posedge clk_i);
    #1;
  endtask

  task automatic sweep_quiet();
    for (int k = 0; k < 32; k++) begin
      expect_slot(pool_pc(5'(k)), 1'b0, 1'b0, 1'b0, '0);
    end
  endtask

  task automatic pulse_ctrl(input logic clr, input logic fl, input int cycles);
    clear_i = clr;
    flush_i = fl;
    repeat (cycles) @(posedge clk_i);
    #1;
    clear_i = 1'b0;
    flush_i = 1'b0;
  endtask

  task automatic fill_streams();
    logic [31:0] r;
    for (int p = 0; p < 2; p++) begin
      for (int j = 0; j < STREAM_LEN; j++) begin
        r = rand_bits(5);
        s_pc[p][j] = pool_pc(r[4:0]);
        s_tk[p][j] = lfsr_bit();
        r = rand_bits(8);
        s_tgt[p][j] = 32'h0004_0000 | {23'b0, r[7:0], 1'b0};
        s_idle[p][j] = lfsr_bit();
      end
    end
  endtask

  task automatic port_stream(input int port, input logic use_idle);
    for (int j = 0; j < STREAM_LEN; j++) begin
      if (use_idle && s_idle[port][j]) begin
        @(posedge clk_i);
        #1;
      end
      send_resolve(port, s_pc[port][j], s_tk[port][j], s_tgt[port][j]);
    end
  endtask

  task automatic sweep_vpc(input int cycles);
    for (int k = 0; k < cycles; k++) begin
      vpc_i = pool_pc(5'(k));
      @(posedge clk_i);
      #1;
    end
  endtask

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  always_comb begin
    int bi;
    int ti;
    for (int i = 0; i < 2; i++) begin
      bi = int'({vpc_i[BHT_HI:2], i[0]});
      ti = int'({vpc_i[BTB_HI:2], i[0]});
      exp_valid[i] = m_bht_v[bi];
      exp_taken[i] = m_bht_c[bi][1];
      exp_tvalid[i] = m_btb_v[ti] && (m_btb_tag[ti] == (vpc_i >> (BTB_HI + 1)));
      exp_target[i] = m_btb_tgt[ti];
    end
    exp_rdy0 = !(clear_i || flush_i) && res0_valid_i && (!res1_valid_i || !favour1);
    exp_rdy1 = !(clear_i || flush_i) && res1_valid_i && (!res0_valid_i || favour1);
  end

  always @(posedge clk_i or negedge rst_ni) begin
    logic [31:0] pc;
    logic [31:0] tgt;
    logic tk;
    int bi;
    int ti;
    if (!rst_ni) begin
      favour1 <= 1'b0;
      for (int e = 0; e < BHT_ENTRIES; e++) {m_bht_v[e], m_bht_c[e]} <= 3'b000;
      for (int e = 0; e < BTB_ENTRIES; e++) m_btb_v[e] <= 1'b0;
    end else begin
      pc = exp_rdy1 ? res1_pc_i : res0_pc_i;
      tgt = exp_rdy1 ? res1_target_i : res0_target_i;
      tk = exp_rdy1 ? res1_taken_i : res0_taken_i;
      bi = int'(pc[BHT_HI:1]);
      ti = int'(pc[BTB_HI:1]);
      if (exp_rdy0) favour1 <= 1'b1;
      else if (exp_rdy1) favour1 <= 1'b0;
      if (exp_rdy0 || exp_rdy1) accepted++;
      if (clear_i) begin
        for (int e = 0; e < BHT_ENTRIES; e++) {m_bht_v[e], m_bht_c[e]} <= 3'b000;
        for (int e = 0; e < BTB_ENTRIES; e++) m_btb_v[e] <= 1'b0;
      end else if (flush_i) begin
        // weakly taken, but invalid
        for (int e = 0; e < BHT_ENTRIES; e++) {m_bht_v[e], m_bht_c[e]} <= 3'b010;
        for (int e = 0; e < BTB_ENTRIES; e++) m_btb_v[e] <= 1'b0;
      end else if ((exp_rdy0 || exp_rdy1) && !debug_mode_i) begin
        m_bht_v[bi] <= 1'b1;
        if (tk && m_bht_c[bi] != 2'b11) m_bht_c[bi] <= m_bht_c[bi] + 2'd1;
        else if (!tk && m_bht_c[bi] != 2'b00) m_bht_c[bi] <= m_bht_c[bi] - 2'd1;
        if (tk) begin
          m_btb_v[ti] <= 1'b1;
          m_btb_tag[ti] <= pc >> (BTB_HI + 1);
          m_btb_tgt[ti] <= tgt;
        end
      end
    end
  end

  // --------------------------------------------------
  // output checks sampled mid-cycle
  // --------------------------------------------------
  a_valid: assert property (@(negedge clk_i) disable iff (!rst_ni) pred_valid_o == exp_valid)
    else report_value("pred_valid_o", {30'b0, pred_valid_o}, {30'b0, exp_valid});
  a_taken: assert property (@(negedge clk_i) disable iff (!rst_ni) pred_taken_o == exp_taken)
    else report_value("pred_taken_o", {30'b0, pred_taken_o}, {30'b0, exp_taken});
  a_tvalid: assert property (@(negedge clk_i) disable iff (!rst_ni)
    pred_target_valid_o == exp_tvalid)
    else report_value("pred_target_valid_o", {30'b0, pred_target_valid_o}, {30'b0, exp_tvalid});
  a_target0: assert property (@(negedge clk_i) disable iff (!rst_ni)
    !exp_tvalid[0] || pred_target_o[0] == exp_target[0])
    else report_value("pred_target_o[0]", pred_target_o[0], exp_target[0]);
  a_target1: assert property (@(negedge clk_i) disable iff (!rst_ni)
    !exp_tvalid[1] || pred_target_o[1] == exp_target[1])
    else report_value("pred_target_o[1]", pred_target_o[1], exp_target[1]);
  a_ready: assert property (@(negedge clk_i) disable iff (!rst_ni)
    {res1_ready_o, res0_ready_o} == {exp_rdy1, exp_rdy0})
    else report_value("res_ready", {30'b0, res1_ready_o, res0_ready_o},
                      {30'b0, exp_rdy1, exp_rdy0});
  a_hold: assert property (@(negedge clk_i) disable iff (!rst_ni)
    (clear_i || flush_i) |-> !(res0_ready_o || res1_ready_o))
    else report_value("res_ready during clear or flush",
                      {30'b0, res1_ready_o, res0_ready_o}, 32'h0);

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    {clk_i, rst_ni, clear_i, flush_i, debug_mode_i} = 5'b00000;
    vpc_i = '0;
    {res0_valid_i, res0_pc_i, res0_taken_i, res0_target_i} = '0;
    {res1_valid_i, res1_pc_i, res1_taken_i, res1_target_i} = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    fill_streams();
    sweep_quiet();

    // counter walks 01, 10, 11, 11 and back down 10, 01
    send_resolve(0, PC_A, 1'b1, TGT_A);
    expect_slot(PC_A, 1'b1, 1'b0, 1'b1, TGT_A);
    send_resolve(0, PC_A, 1'b1, TGT_A);
    expect_slot(PC_A, 1'b1, 1'b1, 1'b1, TGT_A);
    send_resolve(1, PC_A, 1'b1, TGT_A);
    expect_slot(PC_A, 1'b1, 1'b1, 1'b1, TGT_A);
    send_resolve(1, PC_A, 1'b1, TGT_A);
    expect_slot(PC_A, 1'b1, 1'b1, 1'b1, TGT_A);
    expect_slot(PC_A_ALIAS, 1'b1, 1'b1, 1'b0, '0);
    send_resolve(0, PC_A, 1'b0, TGT_B);
    expect_slot(PC_A, 1'b1, 1'b1, 1'b1, TGT_A);
    send_resolve(1, PC_A, 1'b0, TGT_B);
    expect_slot(PC_A, 1'b1, 1'b0, 1'b1, TGT_A);

    // debug mode consumes without training
    debug_mode_i = 1'b1;
    send_resolve(0, PC_B, 1'b1, TGT_B);
    send_resolve(1, PC_B, 1'b1, TGT_B);
    debug_mode_i = 1'b0;
    expect_slot(PC_B, 1'b0, 1'b0, 1'b0, '0);

    // both ports busy every cycle, then with random gaps
    fork
      port_stream(0, 1'b0);
      port_stream(1, 1'b0);
      sweep_vpc(2 * STREAM_LEN);
    join
    fork
      port_stream(0, 1'b1);
      port_stream(1, 1'b1);
      sweep_vpc(3 * STREAM_LEN);
    join

    pulse_ctrl(1'b1, 1'b0, 2);
    sweep_quiet();

    // a resolve held off by a flush steps the counter from 10 to 01
    fork
      pulse_ctrl(1'b0, 1'b1, 2);
      send_resolve(0, PC_A, 1'b0, TGT_A);
    join
    expect_slot(PC_B, 1'b0, 1'b1, 1'b0, '0);
    expect_slot(PC_A, 1'b1, 1'b0, 1'b0, '0);

    // a resolve held off by a clear steps the counter from 00 to 01
    fork
      pulse_ctrl(1'b1, 1'b0, 2);
      send_resolve(1, PC_A, 1'b1, TGT_B);
    join
    expect_slot(PC_A, 1'b1, 1'b0, 1'b1, TGT_B);

    chk_transfers: assert (sent == accepted)
      else begin
        errors++;
        $display("transfer count mismatch: %0d sent, %0d applied by the model", sent, accepted);
      end
    $display("errors %0d, timeouts %0d, transfers %0d", errors, timeouts, accepted);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
hw/bp_pkg.sv
hw/bp_update_if.sv
hw/bp_update_arbiter.sv
hw/bht.sv
hw/btb.sv
hw/branch_predictor.sv
bench/tb_branch_predictor.sv

//--- run.sh
#!/usr/bin/env bash
# build the branch predictor testbench with Verilator, run it and check the log
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_branch_predictor \
  -f project.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
